/* verilog/rvseed_pkg.sv */
package rvseed_pkg;

    // Data and address width, one word.
    parameter int cpu_width = 32;

    typedef logic [31:0] inst_t;  // Raw instruction word.

    parameter logic [cpu_width-1:0] reset_pc_default = 32'h8000_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes, bits 6:0.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    parameter logic [6:0] op_jal    = 7'b1101111;
    parameter logic [6:0] op_jalr   = 7'b1100111;
    parameter logic [6:0] op_branch = 7'b1100011;
    parameter logic [6:0] op_load   = 7'b0000011;
    parameter logic [6:0] op_store  = 7'b0100011;
    parameter logic [6:0] op_op     = 7'b0110011;
    parameter logic [6:0] op_imm    = 7'b0010011;

    // M extension and branch function codes.
    parameter logic [6:0] funct7_muldiv = 7'b0000001;
    parameter logic [2:0] f3_mul        = 3'b000;
    parameter logic [2:0] f3_divu       = 3'b101;
    parameter logic [2:0] f3_beq        = 3'b000;

endpackage

/* verilog/pc_predict.sv */
`timescale 1ns/100ps

module pc_predict #(
    parameter logic [rvseed_pkg::cpu_width-1:0] reset_pc = rvseed_pkg::reset_pc_default
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             fetch_done,
    input  logic [rvseed_pkg::cpu_width-1:0] id_next_pc,
    input  logic                             control_rest,
    input  logic                             sig_jalr,
    input  logic                             rest_id_mem,
    input  logic                             id_mul,
    input  logic                             id_div,
    input  logic                             sh_fnsh_flag,
    input  logic                             div_finish,
    output logic                             ena,
    output logic                             advance,
    output logic [rvseed_pkg::cpu_width-1:0] axi_curr_pc
);
    import rvseed_pkg::*;

    logic [cpu_width-1:0] curr_pc;
    logic [cpu_width-1:0] pc_next;
    logic                 pending;     // Fetch returned, next address not chosen yet.
    logic                 hold_q;      // Delayed copy of the mem and JALR holds.
    logic                 mul_done_q;
    logic                 div_done_q;
    logic                 take;        // Address settles this cycle.
    logic                 load;        // Take the decoder target instead of pc + 4.
    logic                 hold_set;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Advance rule, highest priority first.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        take     = 1'b0;
        load     = 1'b0;
        hold_set = 1'b0;
        if (pending) begin
            if (id_mul) begin
                take = mul_done_q;                 // Wait for the product.
            end else if (id_div) begin
                take = div_done_q;                 // Wait for the quotient.
            end else if (rest_id_mem) begin
                take     = hold_q;
                hold_set = ~hold_q;
            end else if (sig_jalr) begin
                take     = hold_q;                 // Target is read one cycle late.
                load     = hold_q;
                hold_set = ~hold_q;
            end else if (control_rest) begin
                take = 1'b1;
                load = 1'b1;
            end else begin
                take = 1'b1;
            end
        end
    end

    assign pc_next = load ? id_next_pc : curr_pc + cpu_width'(4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ena        <= 1'b0;
            advance    <= 1'b0;
            pending    <= 1'b0;
            hold_q     <= 1'b0;
            mul_done_q <= 1'b0;
            div_done_q <= 1'b0;
            curr_pc    <= reset_pc;
        end else begin
            ena        <= 1'b1;
            advance    <= take;                    // One pulse per settled address.
            mul_done_q <= sh_fnsh_flag;
            div_done_q <= div_finish;
            if (fetch_done) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
            if (take) begin
                curr_pc <= pc_next;
                hold_q  <= 1'b0;
            end else if (hold_set) begin
                hold_q <= 1'b1;
            end
        end
    end

    assign axi_curr_pc = curr_pc;

endmodule

/* verilog/fetch_port.sv */
`timescale 1ns/100ps

module fetch_port (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ena,
    input  logic                             advance,
    input  logic                             fetch_done,
    input  rvseed_pkg::inst_t                fetch_data,
    input  logic [rvseed_pkg::cpu_width-1:0] axi_curr_pc,
    output logic                             fetch_req,
    output rvseed_pkg::inst_t                id_inst,
    output logic [rvseed_pkg::cpu_width-1:0] id_curr_pc,
    output logic                             id_valid
);

    logic started;    // First request has gone out.
    logic req_q;      // Request held until memory answers.
    logic first_req;

    assign first_req = ena & ~started;

    // Request shows in the same cycle as the advance pulse.
    assign fetch_req = req_q | advance | first_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started  <= 1'b0;
            req_q    <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            id_valid <= fetch_done;
            if (ena) begin
                started <= 1'b1;
            end
            if (fetch_done) begin
                req_q <= 1'b0;                 // Drops in the cycle after done.
            end else if (advance | first_req) begin
                req_q <= 1'b1;
            end
        end
    end

    // Returned word and the address it came from.
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            id_inst    <= fetch_data;
            id_curr_pc <= axi_curr_pc;
        end
    end

endmodule

/* verilog/inst_decode.sv */
`timescale 1ns/100ps

module inst_decode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  rvseed_pkg::inst_t                id_inst,
    input  logic [rvseed_pkg::cpu_width-1:0] id_curr_pc,
    input  logic                             id_valid,
    input  logic [rvseed_pkg::cpu_width-1:0] operand_a,
    input  logic [rvseed_pkg::cpu_width-1:0] operand_b,
    output logic [rvseed_pkg::cpu_width-1:0] id_next_pc,
    output logic                             control_rest,
    output logic                             sig_jalr,
    output logic                             rest_id_mem,
    output logic                             id_mul,
    output logic                             id_div,
    output logic                             mul_start,
    output logic                             div_start
);
    import rvseed_pkg::*;

    logic                 have_inst;   // A word has been latched since reset.
    logic                 live;
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [cpu_width-1:0] imm_i;
    logic [cpu_width-1:0] imm_b;
    logic [cpu_width-1:0] imm_j;
    logic [cpu_width-1:0] jalr_sum;
    logic                 is_muldiv;
    logic                 is_mul;
    logic                 is_div;
    logic                 is_beq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_inst <= 1'b0;
        end else if (id_valid) begin
            have_inst <= 1'b1;
        end
    end

    // Levels follow the latched word, so they hold until the next id_valid.
    assign live   = id_valid | have_inst;
    assign opcode = id_inst[6:0];
    assign funct3 = id_inst[14:12];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediate formats.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_i = {{20{id_inst[31]}}, id_inst[31:20]};
    assign imm_b = {{19{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};
    assign imm_j = {{11{id_inst[31]}}, id_inst[31], id_inst[19:12], id_inst[20],
                    id_inst[30:21], 1'b0};

    assign is_muldiv = (opcode == op_op) && (id_inst[31:25] == funct7_muldiv);
    assign is_mul    = is_muldiv && (funct3 == f3_mul);
    assign is_div    = is_muldiv && (funct3 == f3_divu);
    assign is_beq    = (opcode == op_branch) && (funct3 == f3_beq);

    assign id_mul       = live & is_mul;
    assign id_div       = live & is_div;
    assign rest_id_mem  = live & ((opcode == op_load) || (opcode == op_store));
    assign sig_jalr     = live & (opcode == op_jalr);
    assign control_rest = live & ((opcode == op_jal) || (is_beq && operand_a == operand_b));

    assign mul_start = id_valid & is_mul;  // One pulse per decoded word.
    assign div_start = id_valid & is_div;

    assign jalr_sum   = operand_a + imm_i;
    assign id_next_pc = (opcode == op_jalr) ? {jalr_sum[cpu_width-1:1], 1'b0} :
                        (opcode == op_jal)  ? id_curr_pc + imm_j :
                                              id_curr_pc + imm_b;

endmodule

/* verilog/shift_multiplier.sv */
`timescale 1ns/100ps

module shift_multiplier (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [rvseed_pkg::cpu_width-1:0] multiplicand,
    input  logic [rvseed_pkg::cpu_width-1:0] multiplier,
    output logic                             sh_fnsh_flag,
    output logic [rvseed_pkg::cpu_width-1:0] product
);
    import rvseed_pkg::*;

    logic [cpu_width-1:0] acc;
    logic [cpu_width-1:0] mcand;       // Shifts left each step.
    logic [cpu_width-1:0] mplier;      // Shifts right, bit 0 picks the add.
    logic [4:0]           step_cnt;
    logic                 busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            step_cnt     <= '0;
            sh_fnsh_flag <= 1'b0;
        end else begin
            sh_fnsh_flag <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 5'd1;
                if (step_cnt == 5'd31) begin
                    busy         <= 1'b0;
                    sh_fnsh_flag <= 1'b1;  // 33 cycles after start.
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Add and shift datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= multiplicand;
            mplier <= multiplier;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;  // Low half only.

endmodule

/* verilog/restoring_divider.sv */
`timescale 1ns/100ps

module restoring_divider (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [rvseed_pkg::cpu_width-1:0] dividend,
    input  logic [rvseed_pkg::cpu_width-1:0] divisor,
    output logic                             div_finish,
    output logic [rvseed_pkg::cpu_width-1:0] quotient
);
    import rvseed_pkg::*;

    logic [cpu_width-1:0] rem;
    logic [cpu_width-1:0] quo;    // Dividend shifts out, quotient bits shift in.
    logic [cpu_width-1:0] dsor;
    logic [cpu_width:0]   trial;
    logic [cpu_width:0]   diff;
    logic [5:0]           step_cnt;
    logic                 busy;
    logic                 step;

    assign step  = busy & ~step_cnt[5];
    assign trial = {rem, quo[cpu_width-1]};
    assign diff  = trial - {1'b0, dsor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            step_cnt   <= '0;
            div_finish <= 1'b0;
        end else begin
            div_finish <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (step) begin
                step_cnt <= step_cnt + 6'd1;
            end else if (busy) begin
                busy       <= 1'b0;           // Closing cycle after step 32.
                div_finish <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One restoring step per cycle.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A zero divisor never makes diff negative, so every bit comes out one.
    always_ff @(posedge clk) begin
        if (start) begin
            rem  <= '0;
            quo  <= dividend;
            dsor <= divisor;
        end else if (step) begin
            if (!diff[cpu_width]) begin
                rem <= diff[cpu_width-1:0];
                quo <= {quo[cpu_width-2:0], 1'b1};
            end else begin
                rem <= trial[cpu_width-1:0];   // Restore.
                quo <= {quo[cpu_width-2:0], 1'b0};
            end
        end
    end

    assign quotient = quo;

endmodule

/* verilog/fetch_core.sv */
`timescale 1ns/100ps

module fetch_core #(
    parameter logic [rvseed_pkg::cpu_width-1:0] reset_pc = rvseed_pkg::reset_pc_default
) (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic                             fetch_req,
    output logic [rvseed_pkg::cpu_width-1:0] fetch_addr,
    input  rvseed_pkg::inst_t                fetch_data,
    input  logic                             fetch_done,
    input  logic [rvseed_pkg::cpu_width-1:0] operand_a,
    input  logic [rvseed_pkg::cpu_width-1:0] operand_b,
    output logic [rvseed_pkg::cpu_width-1:0] result,
    output logic                             result_valid
);
    import rvseed_pkg::*;

    logic                 ena;
    logic                 advance;
    logic [cpu_width-1:0] axi_curr_pc;
    inst_t                id_inst;
    logic [cpu_width-1:0] id_curr_pc;
    logic                 id_valid;
    logic [cpu_width-1:0] id_next_pc;
    logic                 control_rest;
    logic                 sig_jalr;
    logic                 rest_id_mem;
    logic                 id_mul;
    logic                 id_div;
    logic                 mul_start;
    logic                 div_start;
    logic                 sh_fnsh_flag;
    logic                 div_finish;
    logic [cpu_width-1:0] product;
    logic [cpu_width-1:0] quotient;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch path.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    pc_predict #(
        .reset_pc(reset_pc)
    ) u_pc_predict (
        .clk, .rst_n, .fetch_done, .id_next_pc,
        .control_rest, .sig_jalr, .rest_id_mem, .id_mul, .id_div,
        .sh_fnsh_flag, .div_finish,
        .ena, .advance, .axi_curr_pc
    );

    fetch_port u_fetch_port (
        .clk, .rst_n, .ena, .advance, .fetch_done, .fetch_data,
        .axi_curr_pc, .fetch_req, .id_inst, .id_curr_pc, .id_valid
    );

    inst_decode u_inst_decode (
        .clk, .rst_n, .id_inst, .id_curr_pc, .id_valid,
        .operand_a, .operand_b, .id_next_pc,
        .control_rest, .sig_jalr, .rest_id_mem, .id_mul, .id_div,
        .mul_start, .div_start
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multicycle units.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    shift_multiplier u_shift_multiplier (
        .clk, .rst_n,
        .start        (mul_start),
        .multiplicand (operand_a),
        .multiplier   (operand_b),
        .sh_fnsh_flag,
        .product
    );

    restoring_divider u_restoring_divider (
        .clk, .rst_n,
        .start    (div_start),
        .dividend (operand_a),
        .divisor  (operand_b),
        .div_finish,
        .quotient
    );

    assign fetch_addr   = axi_curr_pc;
    assign result       = sh_fnsh_flag ? product : quotient;  // Only one unit runs at a time.
    assign result_valid = sh_fnsh_flag | div_finish;

endmodule

/* bench/fetch_core_assertions.sv */
`timescale 1ns/100ps

module fetch_core_assertions (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             fetch_req,
    input logic                             advance,
    input logic [rvseed_pkg::cpu_width-1:0] axi_curr_pc,
    input logic                             id_mul,
    input logic                             id_div,
    input logic                             sh_fnsh_flag,
    input logic                             div_finish
);

    // No request leaves the core while it is in reset.
    req_low_in_reset: assert property (@(negedge clk) !rst_n |-> !fetch_req)
        else $error("fetch_req is high during reset");

    // The fetch address only moves together with the advance pulse.
    pc_moves_on_advance: assert property (@(posedge clk) disable iff (!rst_n)
        (axi_curr_pc != $past(axi_curr_pc)) |-> advance)
        else $error("fetch address changed without an advance");

    // Advance under a multiply or divide follows its finish flag by two cycles.
    mul_holds_advance: assert property (@(posedge clk) disable iff (!rst_n)
        (advance && id_mul) |-> $past(sh_fnsh_flag, 2))
        else $error("advance during a multiply before its finish flag");

    div_holds_advance: assert property (@(posedge clk) disable iff (!rst_n)
        (advance && id_div) |-> $past(div_finish, 2))
        else $error("advance during a divide before its finish flag");

endmodule

bind fetch_core fetch_core_assertions u_fetch_core_assertions (
    .clk, .rst_n, .fetch_req, .advance, .axi_curr_pc,
    .id_mul, .id_div, .sh_fnsh_flag, .div_finish
);

/* bench/fetch_core_tb.sv */
`timescale 1ns/100ps

module fetch_core_tb;
    import rvseed_pkg::*;

    localparam int n_rows  = 12;
    localparam int timeout = 200;   // Cycles allowed for any one wait.

    localparam logic [cpu_width-1:0] boot_pc = 32'h4000_0000;  // Start address for the DUT.

    logic                 clk;
    logic                 rst_n;
    logic                 fetch_req;
    logic [cpu_width-1:0] fetch_addr;
    inst_t                fetch_data;
    logic                 fetch_done;
    logic [cpu_width-1:0] operand_a;
    logic [cpu_width-1:0] operand_b;
    logic [cpu_width-1:0] result;
    logic                 result_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    string                row_name   [n_rows];
    logic [cpu_width-1:0] row_addr   [n_rows];
    inst_t                row_inst   [n_rows];
    logic [cpu_width-1:0] row_a      [n_rows];
    logic [cpu_width-1:0] row_b      [n_rows];
    logic [cpu_width-1:0] row_expect [n_rows];   // Next fetch address, or the M result.
    bit                   row_is_m   [n_rows];
    int                   row_lat    [n_rows];   // Cycles until the next request.

    integer seed = 1;
    int     n_loaded;
    int     errors;
    int     passed;
    bit     timed_out;

    fetch_core #(
        .reset_pc(boot_pc)
    ) UUT (
        .clk, .rst_n, .fetch_req, .fetch_addr, .fetch_data, .fetch_done,
        .operand_a, .operand_b, .result, .result_valid
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_row(input string name, input logic [31:0] addr, input inst_t inst,
                           input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] expect_val, input bit is_m, input int lat);
        row_name[n_loaded]   = name;
        row_addr[n_loaded]   = addr;
        row_inst[n_loaded]   = inst;
        row_a[n_loaded]      = a;
        row_b[n_loaded]      = b;
        row_expect[n_loaded] = expect_val;
        row_is_m[n_loaded]   = is_m;
        row_lat[n_loaded]    = lat;
        n_loaded++;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual,
                               inout int count);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
            count++;
        end
    endtask

    task automatic wait_request(input string test);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!fetch_req && waited < timeout);
        assert (fetch_req) else begin
            $display("%s: timed out waiting for a fetch request", test);
            timed_out = 1'b1;
        end
    endtask

    // Memory answers one fetch, then the next request is traced.
    task automatic run_row(input int idx);
        int delay;
        int lat;
        int waited;
        int row_errors;
        bit seen_valid;
        row_errors = 0;
        wait_request(row_name[idx]);
        if (timed_out) begin
            row_errors++;
        end else begin
            check_value(row_name[idx], "fetch address", row_addr[idx], fetch_addr, row_errors);
            delay = 1 + ($unsigned($random(seed)) % 4);   // 1 to 4 cycles.
            repeat (delay) @(posedge clk);
            fetch_done <= 1'b1;
            fetch_data <= row_inst[idx];
            operand_a  <= row_a[idx];
            operand_b  <= row_b[idx];
            @(posedge clk);
            fetch_done <= 1'b0;
            lat        = 0;
            waited     = 0;
            seen_valid = 1'b0;
            do begin
                @(negedge clk);
                lat++;
                waited++;
                if (result_valid) begin
                    assert (row_is_m[idx]) else begin
                        $display("%s: result_valid without a multiply or divide", row_name[idx]);
                        row_errors++;
                    end
                    check_value(row_name[idx], "result", row_expect[idx], result, row_errors);
                    seen_valid = 1'b1;
                    lat        = 0;   // Count from the finish flag.
                end
            end while (!fetch_req && waited < timeout);
            assert (fetch_req) else begin
                $display("%s: timed out waiting for the next fetch request", row_name[idx]);
                timed_out = 1'b1;
                row_errors++;
            end
            assert (!fetch_req || !row_is_m[idx] || seen_valid) else begin
                $display("%s: fetch requested before result_valid", row_name[idx]);
                row_errors++;
            end
            if (fetch_req && (seen_valid || !row_is_m[idx])) begin
                check_value(row_name[idx], "request latency", row_lat[idx], lat, row_errors);
                if (!row_is_m[idx]) begin
                    check_value(row_name[idx], "next fetch address", row_expect[idx],
                                fetch_addr, row_errors);
                end
            end
        end
        errors += row_errors;
        if (row_errors == 0) begin
            passed++;
            $display("%-16s ok", row_name[idx]);
        end else begin
            $display("%-16s failed, %0d errors", row_name[idx], row_errors);
        end
    endtask

    initial begin
        int i;
        n_loaded   = 0;
        errors     = 0;
        passed     = 0;
        timed_out  = 1'b0;
        rst_n      = 1'b0;
        fetch_done = 1'b0;
        fetch_data = '0;
        operand_a  = '0;
        operand_b  = '0;
        //      name            addr          inst          a             b
        //      expect          M  latency
        add_row("alu_addi",      32'h4000_0000, 32'h0010_0093, 32'h0,         32'h0,
                32'h4000_0004, 0, 2);
        add_row("alu_add",       32'h4000_0004, 32'h0020_81B3, 32'h0,         32'h0,
                32'h4000_0008, 0, 2);
        add_row("jal_fwd",       32'h4000_0008, 32'h0100_00EF, 32'h0,         32'h0,
                32'h4000_0018, 0, 2);
        add_row("beq_taken",     32'h4000_0018, 32'hFE20_8CE3, 32'h5,         32'h5,
                32'h4000_0010, 0, 2);   // Back by 8.
        add_row("beq_not_taken", 32'h4000_0010, 32'hFE20_8CE3, 32'h5,         32'h6,
                32'h4000_0014, 0, 2);
        add_row("jalr",          32'h4000_0014, 32'h0212_80E7, 32'h4000_0100, 32'h0,
                32'h4000_0120, 0, 3);   // 0x121 with bit 0 cleared.
        add_row("load_lw",       32'h4000_0120, 32'h0000_A103, 32'h0,         32'h0,
                32'h4000_0124, 0, 3);
        add_row("store_sw",      32'h4000_0124, 32'h0020_A223, 32'h0,         32'h0,
                32'h4000_0128, 0, 3);
        add_row("mul_low",       32'h4000_0128, 32'h0220_81B3, 32'h0001_0003, 32'h0002_0005,
                32'h000B_000F, 1, 2);   // High word drops out.
        add_row("divu",          32'h4000_012C, 32'h0220_D1B3, 32'd1000,      32'd7,
                32'd142,       1, 2);
        add_row("divu_zero",     32'h4000_0130, 32'h0220_D1B3, 32'h0000_1234, 32'h0,
                32'hFFFF_FFFF, 1, 2);
        add_row("alu_tail",      32'h4000_0134, 32'h0010_0093, 32'h0,         32'h0,
                32'h4000_0138, 0, 2);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (i = 0; i < n_rows && !timed_out; i++) begin
            run_row(i);
        end

        $display("Rows: %0d, passed: %0d, failed: %0d, errors: %0d",
                 n_rows, passed, n_rows - passed, errors);
        if (errors == 0 && passed == n_rows) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/rvseed_pkg.sv
verilog/pc_predict.sv
verilog/fetch_port.sv
verilog/inst_decode.sv
verilog/shift_multiplier.sv
verilog/restoring_divider.sv
verilog/fetch_core.sv
bench/fetch_core_assertions.sv
bench/fetch_core_tb.sv
